// ==== Makefile ====
TOP = rv_pipeline_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f
	verilator --lint-only -Wall --top-module rv_pipeline \
		source/rv_isa_pkg.sv source/core_pkg.sv source/program_memory.sv \
		source/fetch_unit.sv source/register_file.sv source/decode_stage.sv \
		source/execute_stage.sv source/result_stage.sv source/rv_pipeline.sv

clean:
	rm -rf obj_dir sim.log

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // internal ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // fetch run state
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALT
    } run_state_e;

    localparam int DEF_IMEM_WORDS = 256;
    localparam int DEF_DMEM_WORDS = 256;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [XLEN-1:0]       instr,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_pc,
    input  logic                  flush,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic                  ex_load,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic                  stall,
    output logic                  halt_req,
    output logic                  illegal,
    output logic                  d_valid,
    output logic [XLEN-1:0]       d_pc,
    output logic [REG_ADDR_W-1:0] d_rd,
    output logic [REG_ADDR_W-1:0] d_rs1,
    output logic [REG_ADDR_W-1:0] d_rs2,
    output logic [XLEN-1:0]       d_op1,
    output logic [XLEN-1:0]       d_op2,
    output logic [XLEN-1:0]       d_imm,
    output alu_op_e               d_alu_op,
    output logic                  d_use_imm,
    output logic                  d_load,
    output logic                  d_store,
    output logic                  d_branch,
    output logic                  d_reg_write
);

    opcode_e opcode;
    funct3_e funct3;
    logic [6:0] funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic legal, ecall, use_imm, is_load, is_store, is_branch, reg_write;
    logic uses_rs1, uses_rs2, live, issue;
    alu_op_e alu_op;
    logic [XLEN-1:0] imm;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = funct3_e'(instr[14:12]);
    assign funct7 = instr[31:25];
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        legal = 1'b1;
        ecall = 1'b0;
        use_imm = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        reg_write = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        alu_op = ALU_ADD;
        imm = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            OP: begin
                uses_rs2 = 1'b1;
                reg_write = 1'b1;
                legal = (funct7 == '0) || (funct7 == FUNCT7_SUB && funct3 == F3_ADD);
                case (funct3)
                    F3_ADD: alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT: alu_op = ALU_SLT;
                    F3_XOR: alu_op = ALU_XOR;
                    F3_OR: alu_op = ALU_OR;
                    F3_AND: alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OP_IMM: begin
                // only ADDI in the subset
                legal = (funct3 == F3_ADD);
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            LOAD: begin
                legal = (funct3 == F3_SLT);
                use_imm = 1'b1;
                is_load = 1'b1;
                reg_write = 1'b1;
            end
            STORE: begin
                legal = (funct3 == F3_SLT);
                use_imm = 1'b1;
                is_store = 1'b1;
                uses_rs2 = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                legal = (funct3 == F3_ADD);
                is_branch = 1'b1;
                uses_rs2 = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            SYSTEM: begin
                legal = (instr == ECALL_WORD);
                ecall = legal;
                uses_rs1 = 1'b0;
            end
            default: legal = 1'b0;
        endcase
    end

    assign live = in_valid && !flush;

    // load in execute feeding this instruction costs one bubble
    assign stall = live && legal && ex_load && ex_rd != '0 &&
                   ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));
    assign halt_req = live && ecall;
    assign issue = live && legal && !stall;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            d_valid <= 1'b0;
            d_load <= 1'b0;
            d_store <= 1'b0;
            d_branch <= 1'b0;
            d_reg_write <= 1'b0;
            illegal <= 1'b0;
        end else begin
            d_valid <= issue;
            d_load <= issue && is_load;
            d_store <= issue && is_store;
            d_branch <= issue && is_branch;
            d_reg_write <= issue && reg_write && rd != '0;
            illegal <= live && !legal;
        end
    end

    always_ff @(posedge clk) begin
        d_pc <= in_pc;
        d_rd <= rd;
        d_rs1 <= rs1;
        d_rs2 <= rs2;
        d_op1 <= rs1_data;
        d_op2 <= rs2_data;
        d_imm <= imm;
        d_alu_op <= alu_op;
        d_use_imm <= use_imm;
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  d_valid,
    input  logic [XLEN-1:0]       d_pc,
    input  logic [REG_ADDR_W-1:0] d_rd,
    input  logic [REG_ADDR_W-1:0] d_rs1,
    input  logic [REG_ADDR_W-1:0] d_rs2,
    input  logic [XLEN-1:0]       d_op1,
    input  logic [XLEN-1:0]       d_op2,
    input  logic [XLEN-1:0]       d_imm,
    input  alu_op_e               d_alu_op,
    input  logic                  d_use_imm,
    input  logic                  d_load,
    input  logic                  d_store,
    input  logic                  d_branch,
    input  logic                  d_reg_write,
    input  logic                  rs_fwd_en,
    input  logic [REG_ADDR_W-1:0] rs_fwd_rd,
    input  logic [XLEN-1:0]       rs_fwd_data,
    output logic                  redirect,
    output logic [XLEN-1:0]       redirect_pc,
    output logic                  flush,
    output logic                  e_valid,
    output logic [REG_ADDR_W-1:0] e_rd,
    output logic [XLEN-1:0]       e_result,
    output logic [XLEN-1:0]       e_store_data,
    output logic                  e_load,
    output logic                  e_store,
    output logic                  e_reg_write
);

    logic [XLEN-1:0] op_a, op_b, alu_b, alu_y;

    // nearest producer wins; loads one ahead never match thanks to the stall
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0] reg_value);
        if (e_valid && e_reg_write && !e_load && e_rd == rs) begin
            return e_result;
        end
        if (rs_fwd_en && rs_fwd_rd == rs) begin
            return rs_fwd_data;
        end
        return reg_value;
    endfunction

    assign op_a = forward(d_rs1, d_op1);
    assign op_b = forward(d_rs2, d_op2);
    assign alu_b = d_use_imm ? d_imm : op_b;

    always_comb begin
        case (d_alu_op)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR: alu_y = op_a | alu_b;
            ALU_XOR: alu_y = op_a ^ alu_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_y = op_a + alu_b;
        endcase
    end

    // not-taken is the prediction, so only a taken BEQ redirects
    assign redirect = d_valid && d_branch && (op_a == op_b);
    assign redirect_pc = d_pc + d_imm;
    assign flush = redirect;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            e_valid <= 1'b0;
            e_load <= 1'b0;
            e_store <= 1'b0;
            e_reg_write <= 1'b0;
        end else begin
            e_valid <= d_valid;
            e_load <= d_valid && d_load;
            e_store <= d_valid && d_store;
            e_reg_write <= d_valid && d_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        e_rd <= d_rd;
        e_result <= alu_y;
        e_store_data <= op_b;
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [XLEN-1:0]               redirect_pc,
    input  logic                          halt_req,
    output logic [$clog2(IMEM_WORDS)-1:0] imem_address,
    output logic                          fetch_valid,
    output logic [XLEN-1:0]               fetch_pc,
    output logic                          halted
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    run_state_e      state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] read_pc;

    // on a stall the word in decode is read again
    assign read_pc = stall ? fetch_pc : pc;
    assign imem_address = read_pc[IDX_W+1:2];
    assign halted = (state == HALT);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            pc <= '0;
            fetch_valid <= 1'b0;
            fetch_pc <= '0;
        end else begin
            case (state)
                RUN: begin
                    if (halt_req) begin
                        state <= HALT;
                        fetch_valid <= 1'b0;
                    end else if (redirect) begin
                        // read in flight is on the wrong path
                        pc <= redirect_pc;
                        fetch_valid <= 1'b0;
                    end else if (!stall) begin
                        pc <= pc + 32'd4;
                        fetch_pc <= pc;
                        fetch_valid <= 1'b1;
                    end
                end
                default: begin
                    fetch_valid <= 1'b0;
                    if (start) begin
                        state <= RUN;
                        pc <= '0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/program_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_memory
    import rv_isa_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [$clog2(IMEM_WORDS)-1:0] wr_address,
    input  logic [XLEN-1:0]               wr_data,
    input  logic [$clog2(IMEM_WORDS)-1:0] rd_address,
    output logic [XLEN-1:0]               rd_data
);

    logic [XLEN-1:0] mem [IMEM_WORDS];

    // host writes, core reads one cycle later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_address] <= wr_data;
        end
        rd_data <= mem[rd_address];
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file
    import rv_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_rd,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // x0 is hardwired, same-cycle write goes straight through
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && wr_rd == rs1) ? wr_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

// ==== source/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import rv_isa_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  e_valid,
    input  logic [REG_ADDR_W-1:0] e_rd,
    input  logic [XLEN-1:0]       e_result,
    input  logic [XLEN-1:0]       e_store_data,
    input  logic                  e_load,
    input  logic                  e_store,
    input  logic                  e_reg_write,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  retire_valid,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]       retire_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  dmem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [XLEN-1:0]  mem_q;
    logic [XLEN-1:0]  alu_q;
    logic             load_q;

    // byte address from the ALU, word aligned
    assign word_idx = e_result[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (e_valid && e_store) begin
            dmem[word_idx] <= e_store_data;
        end
        mem_q <= dmem[word_idx];
        alu_q <= e_result;
        load_q <= e_load;
        wb_rd <= e_rd;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= e_valid && e_reg_write;
        end
    end

    assign wb_data = load_q ? mem_q : alu_q;

    // every register write is a retire
    assign retire_valid = wb_en;
    assign retire_rd = wb_rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    // major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 codes; 000 doubles as BEQ/ECALL, 010 as the word width of LW/SW
    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;
    localparam logic [XLEN-1:0] ECALL_WORD = 32'h0000_0073;

endpackage

`default_nettype wire

// ==== source/rv_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = DEF_IMEM_WORDS,
    parameter int DMEM_WORDS = DEF_DMEM_WORDS
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          load_valid,
    input  logic [$clog2(IMEM_WORDS)-1:0] load_address,
    input  logic [XLEN-1:0]               load_data,
    input  logic                          start,
    output logic                          retire_valid,
    output logic [REG_ADDR_W-1:0]         retire_rd,
    output logic [XLEN-1:0]               retire_data,
    output logic                          illegal,
    output logic                          halted
);

    logic [$clog2(IMEM_WORDS)-1:0] imem_address;
    logic [XLEN-1:0] instr, fetch_pc, redirect_pc;
    logic fetch_valid, stall, halt_req, redirect, flush;
    logic [REG_ADDR_W-1:0] rs1, rs2;
    logic [XLEN-1:0] rs1_data, rs2_data;

    // decode to execute
    logic d_valid, d_use_imm, d_load, d_store, d_branch, d_reg_write;
    logic [XLEN-1:0] d_pc, d_op1, d_op2, d_imm;
    logic [REG_ADDR_W-1:0] d_rd, d_rs1, d_rs2;
    alu_op_e d_alu_op;

    // execute to result
    logic e_valid, e_load, e_store, e_reg_write;
    logic [REG_ADDR_W-1:0] e_rd;
    logic [XLEN-1:0] e_result, e_store_data;

    logic wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0] wb_data;

    program_memory #(.IMEM_WORDS(IMEM_WORDS)) program_memory_inst (
        .clk(clk), .wr_en(load_valid), .wr_address(load_address),
        .wr_data(load_data), .rd_address(imem_address), .rd_data(instr)
    );

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch_unit_inst (
        .clk(clk), .reset_n(reset_n), .start(start), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt_req(halt_req),
        .imem_address(imem_address), .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc), .halted(halted)
    );

    register_file register_file_inst (
        .clk(clk), .reset_n(reset_n), .rs1(rs1), .rs2(rs2),
        .wr_en(wb_en), .wr_rd(wb_rd), .wr_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .reset_n(reset_n), .instr(instr), .in_valid(fetch_valid),
        .in_pc(fetch_pc), .flush(flush), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_load(d_load), .ex_rd(d_rd), .rs1(rs1), .rs2(rs2), .stall(stall),
        .halt_req(halt_req), .illegal(illegal), .d_valid(d_valid), .d_pc(d_pc),
        .d_rd(d_rd), .d_rs1(d_rs1), .d_rs2(d_rs2), .d_op1(d_op1), .d_op2(d_op2),
        .d_imm(d_imm), .d_alu_op(d_alu_op), .d_use_imm(d_use_imm), .d_load(d_load),
        .d_store(d_store), .d_branch(d_branch), .d_reg_write(d_reg_write)
    );

    execute_stage execute_stage_inst (
        .clk(clk), .reset_n(reset_n), .d_valid(d_valid), .d_pc(d_pc), .d_rd(d_rd),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_op1(d_op1), .d_op2(d_op2), .d_imm(d_imm),
        .d_alu_op(d_alu_op), .d_use_imm(d_use_imm), .d_load(d_load),
        .d_store(d_store), .d_branch(d_branch), .d_reg_write(d_reg_write),
        .rs_fwd_en(wb_en), .rs_fwd_rd(wb_rd), .rs_fwd_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush),
        .e_valid(e_valid), .e_rd(e_rd), .e_result(e_result),
        .e_store_data(e_store_data), .e_load(e_load), .e_store(e_store),
        .e_reg_write(e_reg_write)
    );

    result_stage #(.DMEM_WORDS(DMEM_WORDS)) result_stage_inst (
        .clk(clk), .reset_n(reset_n), .e_valid(e_valid), .e_rd(e_rd),
        .e_result(e_result), .e_store_data(e_store_data), .e_load(e_load),
        .e_store(e_store), .e_reg_write(e_reg_write), .wb_en(wb_en),
        .wb_rd(wb_rd), .wb_data(wb_data), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

`default_nettype wire

// ==== src.f ====
source/rv_isa_pkg.sv
source/core_pkg.sv
source/program_memory.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/rv_pipeline.sv
tests/rv_pipeline_tb.sv

// ==== tests/rv_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_tb
    import rv_isa_pkg::*;
    import core_pkg::*;
();

    localparam int NUM_TESTS = 5;
    localparam int MAX_WORDS = 16;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 6;
    localparam int IMEM_ADDR_W = $clog2(DEF_IMEM_WORDS);

    logic                  clk;
    logic                  reset_n;
    logic                  load_valid;
    logic [IMEM_ADDR_W-1:0] load_address;
    logic [XLEN-1:0]       load_data;
    logic                  start;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;
    logic                  illegal;
    logic                  halted;

    // one row per test program
    string                 test_name [NUM_TESTS];
    logic [XLEN-1:0]       program_words [NUM_TESTS][MAX_WORDS];
    int                    program_len [NUM_TESTS];
    logic [REG_ADDR_W-1:0] exp_rd [NUM_TESTS][MAX_WORDS];
    logic [XLEN-1:0]       exp_data [NUM_TESTS][MAX_WORDS];
    int                    exp_retires [NUM_TESTS];
    int                    exp_illegal [NUM_TESTS];

    rv_pipeline #(
        .IMEM_WORDS(DEF_IMEM_WORDS),
        .DMEM_WORDS(DEF_DMEM_WORDS)
    ) rv_pipeline_inst (
        .clk(clk), .reset_n(reset_n), .load_valid(load_valid),
        .load_address(load_address), .load_data(load_data), .start(start),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .illegal(illegal), .halted(halted)
    );

    always #4 clk = ~clk;

    function automatic logic [XLEN-1:0] encode_r(input funct3_e f3, input int sub,
                                                 input int rd, input int rs1, input int rs2);
        logic [6:0] funct7;
        funct7 = (sub != 0) ? FUNCT7_SUB : 7'd0;
        return {funct7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
    endfunction

    function automatic logic [XLEN-1:0] encode_i(input opcode_e op, input funct3_e f3,
                                                 input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    // 010 is the word width for LW and SW
    function automatic logic [XLEN-1:0] encode_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_SLT, imm[4:0], STORE};
    endfunction

    function automatic logic [XLEN-1:0] encode_beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], F3_ADD, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] encode_ecall();
        return {25'd0, SYSTEM};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_retire(input string name,
                                input logic [REG_ADDR_W-1:0] want_rd,
                                input logic [XLEN-1:0] want_value,
                                input logic [REG_ADDR_W-1:0] got_rd,
                                input logic [XLEN-1:0] got_value);
        if (got_rd !== want_rd || got_value !== want_value) begin
            abort_run($sformatf("** Error: %s retire expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                                name, want_rd, want_value, got_rd, got_value));
        end
    endtask

    task automatic check_count(input string name, input int want, input int got);
        if (got != want) begin
            abort_run($sformatf("** Error: %s illegal count expected %0d, actual %0d",
                                name, want, got));
        end
    endtask

    task automatic check_halted(input string name, input logic want, input logic got);
        if (got !== want) begin
            abort_run($sformatf("** Error: %s halted expected %0b, actual %0b", name, want, got));
        end
    endtask

    // rd of zero means the instruction must not retire
    task automatic add_instr(input int t, input logic [XLEN-1:0] word,
                             input int rd, input int value);
        program_words[t][program_len[t]] = word;
        program_len[t]++;
        if (rd != 0) begin
            exp_rd[t][exp_retires[t]] = rd[REG_ADDR_W-1:0];
            exp_data[t][exp_retires[t]] = value;
            exp_retires[t]++;
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            program_len[t] = 0;
            exp_retires[t] = 0;
            exp_illegal[t] = 0;
        end
        // each result feeds the next one
        test_name[0] = "alu_chain";
        add_instr(0, encode_i(OP_IMM, F3_ADD, 1, 0, 5), 1, 5);
        add_instr(0, encode_r(F3_ADD, 0, 2, 1, 1), 2, 10);
        add_instr(0, encode_r(F3_ADD, 1, 3, 2, 1), 3, 5);
        add_instr(0, encode_r(F3_XOR, 0, 4, 3, 2), 4, 15);
        add_instr(0, encode_r(F3_AND, 0, 5, 4, 2), 5, 10);
        add_instr(0, encode_r(F3_OR, 0, 6, 5, 1), 6, 15);
        add_instr(0, encode_r(F3_SLT, 0, 7, 1, 6), 7, 1);
        add_instr(0, encode_i(OP_IMM, F3_ADD, 8, 7, -3), 8, -2);
        add_instr(0, encode_r(F3_SLT, 0, 9, 8, 7), 9, 1);
        add_instr(0, encode_ecall(), 0, 0);
        // word at byte address 72
        test_name[1] = "store_load";
        add_instr(1, encode_i(OP_IMM, F3_ADD, 1, 0, 64), 1, 64);
        add_instr(1, encode_i(OP_IMM, F3_ADD, 2, 0, 291), 2, 291);
        add_instr(1, encode_s(2, 1, 8), 0, 0);
        add_instr(1, encode_i(LOAD, F3_SLT, 3, 1, 8), 3, 291);
        add_instr(1, encode_r(F3_ADD, 0, 4, 3, 3), 4, 582);
        add_instr(1, encode_i(LOAD, F3_SLT, 5, 1, 8), 5, 291);
        add_instr(1, encode_i(OP_IMM, F3_ADD, 6, 0, 7), 6, 7);
        add_instr(1, encode_r(F3_ADD, 1, 7, 5, 6), 7, 284);
        add_instr(1, encode_ecall(), 0, 0);
        // taken at pc 8 skips 12 and 16 while pc 24 falls through
        test_name[2] = "beq_paths";
        add_instr(2, encode_i(OP_IMM, F3_ADD, 1, 0, 3), 1, 3);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 2, 0, 3), 2, 3);
        add_instr(2, encode_beq(1, 2, 12), 0, 0);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 3, 0, 111), 0, 0);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 4, 0, 222), 0, 0);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 5, 0, 9), 5, 9);
        add_instr(2, encode_beq(1, 5, 8), 0, 0);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 6, 0, 10), 6, 10);
        add_instr(2, encode_i(OP_IMM, F3_ADD, 7, 6, 1), 7, 11);
        add_instr(2, encode_ecall(), 0, 0);
        test_name[3] = "illegal_word";
        add_instr(3, encode_i(OP_IMM, F3_ADD, 1, 0, 1), 1, 1);
        add_instr(3, 32'hFFFF_FFFF, 0, 0);
        add_instr(3, encode_i(OP_IMM, F3_ADD, 2, 1, 2), 2, 3);
        add_instr(3, encode_r(F3_ADD, 0, 3, 2, 1), 3, 4);
        add_instr(3, encode_ecall(), 0, 0);
        exp_illegal[3] = 1;
        // x0 writes stay invisible
        test_name[4] = "restart_x0";
        add_instr(4, encode_i(OP_IMM, F3_ADD, 0, 0, 5), 0, 0);
        add_instr(4, encode_i(OP_IMM, F3_ADD, 1, 0, 42), 1, 42);
        add_instr(4, encode_r(F3_ADD, 0, 0, 1, 1), 0, 0);
        add_instr(4, encode_r(F3_ADD, 0, 2, 0, 1), 2, 42);
        add_instr(4, encode_ecall(), 0, 0);
    endtask

    task automatic run_test(input int t);
        int retired;
        int illegal_seen;
        int drain;
        logic [XLEN-1:0] word;
        retired = 0;
        illegal_seen = 0;
        drain = 0;
        // spare words past the program write x31 and must never retire
        for (int i = 0; i < MAX_WORDS; i++) begin
            word = (i < program_len[t]) ? program_words[t][i] :
                   encode_i(OP_IMM, F3_ADD, 31, 0, -1);
            repeat ($urandom % 4) begin
                @(posedge clk);
                #1;
            end
            load_valid = 1'b1;
            load_address = i[IMEM_ADDR_W-1:0];
            load_data = word;
            @(posedge clk);
            #1;
            load_valid = 1'b0;
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // older instructions still drain after halted rises
        while (drain < DRAIN_CYCLES) begin
            @(negedge clk);
            if (retire_valid) begin
                if (retired >= exp_retires[t]) begin
                    abort_run($sformatf("%s: unexpected retire of x%0d after the last expected one",
                                        test_name[t], retire_rd));
                end else begin
                    check_retire(test_name[t], exp_rd[t][retired], exp_data[t][retired],
                                 retire_rd, retire_data);
                    retired++;
                end
            end
            if (illegal) begin
                illegal_seen++;
            end
            if (drain > 0) begin
                check_halted(test_name[t], 1'b1, halted);
            end
            if (halted) begin
                drain++;
            end
        end
        if (retired != exp_retires[t]) begin
            abort_run($sformatf("%s: only %0d of %0d expected retires arrived",
                                test_name[t], retired, exp_retires[t]));
        end
        check_count(test_name[t], exp_illegal[t], illegal_seen);
    endtask

    initial begin
        void'($urandom(92876));
        clk = 1'b0;
        reset_n = 1'b0;
        load_valid = 1'b0;
        load_address = '0;
        load_data = '0;
        start = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("All checks passed");
        $finish;
    end

    // budget of 200 cycles per program
    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 200) @(posedge clk);
        abort_run("watchdog expired before all programs halted");
    end

endmodule

`default_nettype wire
